/* logic/cp0_pkg.sv */
`default_nettype none

package cp0_pkg;

    // Register addresses as {number, select}
    localparam logic [7:0] CP0_INDEX    = {5'd0, 3'd0};
    localparam logic [7:0] CP0_ENTRYLO0 = {5'd2, 3'd0};
    localparam logic [7:0] CP0_ENTRYLO1 = {5'd3, 3'd0};
    localparam logic [7:0] CP0_CONTEXT  = {5'd4, 3'd0};
    localparam logic [7:0] CP0_BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0] CP0_COUNT    = {5'd9, 3'd0};
    localparam logic [7:0] CP0_ENTRYHI  = {5'd10, 3'd0};
    localparam logic [7:0] CP0_COMPARE  = {5'd11, 3'd0};
    localparam logic [7:0] CP0_STATUS   = {5'd12, 3'd0};
    localparam logic [7:0] CP0_CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0] CP0_EPC      = {5'd14, 3'd0};
    localparam logic [7:0] CP0_PRID     = {5'd15, 3'd0};
    localparam logic [7:0] CP0_EBASE    = {5'd15, 3'd1};
    localparam logic [7:0] CP0_CONFIG   = {5'd16, 3'd0};
    localparam logic [7:0] CP0_CONFIG1  = {5'd16, 3'd1};

    localparam logic [31:0] STATUS_RESET  = 32'h1040_0004; // CU0, BEV, ERL
    localparam logic [31:0] PRID_VALUE    = 32'h0001_8000; // 4Kc class core
    localparam logic [31:0] CONFIG1_VALUE = {1'b0, 6'd15, 3'd0, 3'd5, 3'd0,
                                             3'd0, 3'd5, 3'd0, 7'd0};

    typedef struct packed {
        logic [2:0] pad31;
        logic       cu0;
        logic [4:0] pad27;
        logic       bev;
        logic [5:0] pad21;
        logic [7:0] im;
        logic [2:0] pad7;
        logic       um;
        logic       pad3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;
        logic [6:0] pad30;
        logic       iv;
        logic [6:0] pad22;
        logic [5:0] ip_hw;
        logic [1:0] ip_sw;
        logic       pad7;
        logic [4:0] exc_code;
        logic [1:0] pad1;
    } cause_t;

    // Same 32 bits, decoded as Status or as Cause
    typedef union packed {
        status_t     status;
        cause_t      cause;
        logic [31:0] raw;
    } cp0_wdata_u;

endpackage

`default_nettype wire

/* logic/exc_pkg.sv */
`default_nettype none

package exc_pkg;

    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    localparam int EXC_REQ_W = 8; // Bit 0 wins

    // Code for each request bit, entry 0 is fetch address error
    localparam logic [EXC_REQ_W-1:0][4:0] EXC_REQ_CODE = {
        EXC_TLBS, EXC_ADES, EXC_OV, EXC_BP,
        EXC_SYS, EXC_RI, EXC_TLBL, EXC_ADEL
    };

    localparam logic [31:0] VEC_GENERAL   = 32'h0000_0180;
    localparam logic [31:0] VEC_INTERRUPT = 32'h0000_0200;
    localparam logic [31:0] BEV_BASE      = 32'hBFC0_0200;

endpackage

`default_nettype wire

/* logic/cp0_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_regs
    import cp0_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  rd_addr_i,
    input  wire  [2:0]  rd_sel_i,
    input  wire         we_i,
    input  wire  [4:0]  wr_addr_i,
    input  wire  [2:0]  wr_sel_i,
    input  wire  [31:0] wdata_i,
    input  wire  [5:0]  hw_int_i,
    input  wire         en_exp_i,
    input  wire  [31:0] exp_epc_i,
    input  wire         exp_bd_i,
    input  wire  [4:0]  exp_code_i,
    input  wire  [31:0] exp_badvaddr_i,
    input  wire         exp_badv_we_i,
    input  wire         clean_exl_i,
    input  wire         probe_we_i,
    input  wire  [31:0] probe_result_i,
    input  wire  [4:0]  dbg_rd_addr_i,
    input  wire  [2:0]  dbg_rd_sel_i,
    output logic [31:0] data_o,
    output logic [31:0] dbg_data_o,
    output cp0_wdata_u  status_o,
    output cp0_wdata_u  cause_o,
    output logic [19:0] ebase_o,
    output logic [31:0] epc_o,
    output logic        timer_int_o,
    output logic        user_mode_o,
    output logic [7:0]  asid_o,
    output logic [89:0] tlb_config_o,
    output logic        kseg0_uncached_o
);

    cp0_wdata_u  wd;
    status_t     status_q;
    cause_t      cause_view;
    logic        cause_bd_q;
    logic        cause_iv_q;
    logic [1:0]  cause_ip_sw_q;
    logic [4:0]  cause_code_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic [17:0] ebase_q;       // EBase[29:12]
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [8:0]  ctx_ptebase_q; // Context[31:23]
    logic [18:0] ctx_badvpn2_q; // Context[22:4]
    logic [18:0] hi_vpn2_q;
    logic [7:0]  hi_asid_q;
    logic [29:0] lo0_q;
    logic [29:0] lo1_q;
    logic        index_p_q;
    logic [3:0]  index_q;
    logic [2:0]  config_k0_q;
    logic        timer_int_q;
    logic        kseg0_uncached_q;
    logic [7:0]  wr_key;
    logic [7:0]  rd_key [2];
    logic [31:0] rd_word [2];

    assign wd.raw = wdata_i;
    assign wr_key = {wr_addr_i, wr_sel_i};
    assign rd_key[0] = {rd_addr_i, rd_sel_i};
    assign rd_key[1] = {dbg_rd_addr_i, dbg_rd_sel_i};
    assign data_o = rd_word[0];
    assign dbg_data_o = rd_word[1];

    // Live view, IP7 also carries the timer
    always_comb begin
        cause_view = '0;
        cause_view.bd = cause_bd_q;
        cause_view.iv = cause_iv_q;
        cause_view.ip_hw = {hw_int_i[5] | timer_int_q, hw_int_i[4:0]};
        cause_view.ip_sw = cause_ip_sw_q;
        cause_view.exc_code = cause_code_q;
    end

    for (genvar p = 0; p < 2; p++) begin : g_rd_port
        always_comb begin
            case (rd_key[p])
                CP0_INDEX:    rd_word[p] = {index_p_q, 27'b0, index_q};
                CP0_ENTRYLO0: rd_word[p] = {2'b0, lo0_q};
                CP0_ENTRYLO1: rd_word[p] = {2'b0, lo1_q};
                CP0_CONTEXT:  rd_word[p] = {ctx_ptebase_q, ctx_badvpn2_q, 4'b0};
                CP0_BADVADDR: rd_word[p] = badvaddr_q;
                CP0_COUNT:    rd_word[p] = count_q;
                CP0_ENTRYHI:  rd_word[p] = {hi_vpn2_q, 5'b0, hi_asid_q};
                CP0_COMPARE:  rd_word[p] = compare_q;
                CP0_STATUS:   rd_word[p] = status_q;
                CP0_CAUSE:    rd_word[p] = cause_view;
                CP0_EPC:      rd_word[p] = epc_q;
                CP0_PRID:     rd_word[p] = PRID_VALUE;
                CP0_EBASE:    rd_word[p] = {2'b10, ebase_q, 12'b0};
                CP0_CONFIG:   rd_word[p] = {1'b1, 21'b0, 3'd1, 4'b0, config_k0_q};
                CP0_CONFIG1:  rd_word[p] = CONFIG1_VALUE;
                default:      rd_word[p] = 32'b0;
            endcase
        end
    end

    // Control state and timer
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q <= STATUS_RESET;
            cause_iv_q <= 1'b0;
            cause_ip_sw_q <= 2'b0;
            count_q <= 32'b0;
            compare_q <= 32'b0;
            ebase_q <= 18'b0;
            config_k0_q <= 3'd3;
            timer_int_q <= 1'b0;
            kseg0_uncached_q <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != 32'b0 && compare_q == count_q)
                timer_int_q <= 1'b1;
            if (we_i) begin
                case (wr_key)
                    CP0_COUNT:   count_q <= wdata_i;
                    CP0_COMPARE: begin
                        compare_q <= wdata_i;
                        timer_int_q <= 1'b0; // Acknowledge
                    end
                    CP0_STATUS: begin
                        status_q.cu0 <= wd.status.cu0;
                        status_q.bev <= wd.status.bev;
                        status_q.im <= wd.status.im;
                        status_q.um <= wd.status.um;
                        status_q.erl <= wd.status.erl;
                        status_q.exl <= wd.status.exl;
                        status_q.ie <= wd.status.ie;
                    end
                    CP0_CAUSE: begin
                        cause_iv_q <= wd.cause.iv;
                        cause_ip_sw_q <= wd.cause.ip_sw;
                    end
                    CP0_EBASE:   ebase_q <= wdata_i[29:12];
                    CP0_CONFIG: begin
                        config_k0_q <= wdata_i[2:0];
                        kseg0_uncached_q <= (wdata_i[2:0] == 3'd2);
                    end
                    default: ;
                endcase
            end
            if (en_exp_i)
                status_q.exl <= 1'b1;
            if (clean_exl_i)
                status_q.exl <= 1'b0;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (we_i) begin
            case (wr_key)
                CP0_INDEX:    index_q <= wdata_i[3:0];
                CP0_ENTRYLO0: lo0_q <= wdata_i[29:0];
                CP0_ENTRYLO1: lo1_q <= wdata_i[29:0];
                CP0_CONTEXT:  ctx_ptebase_q <= wdata_i[31:23];
                CP0_ENTRYHI: begin
                    hi_vpn2_q <= wdata_i[31:13];
                    hi_asid_q <= wdata_i[7:0];
                end
                CP0_EPC:      epc_q <= wdata_i;
                default: ;
            endcase
        end
        if (probe_we_i) begin
            index_p_q <= probe_result_i[31];
            index_q <= probe_result_i[3:0];
        end
        if (en_exp_i) begin
            epc_q <= exp_epc_i;
            cause_bd_q <= exp_bd_i;
            cause_code_q <= exp_code_i;
            if (exp_badv_we_i) begin
                badvaddr_q <= exp_badvaddr_i;
                ctx_badvpn2_q <= exp_badvaddr_i[31:13];
                hi_vpn2_q <= exp_badvaddr_i[31:13];
            end
        end
    end

    assign status_o.status = status_q;
    assign cause_o.cause = cause_view;
    assign ebase_o = {2'b10, ebase_q};
    assign epc_o = epc_q;
    assign timer_int_o = timer_int_q;
    assign user_mode_o = status_q.um & ~status_q.erl & ~status_q.exl;
    assign asid_o = hi_asid_q;
    assign kseg0_uncached_o = kseg0_uncached_q;

    // Packed entry for the TLB write port
    assign tlb_config_o = {
        lo0_q[5:3],
        lo1_q[5:3],
        hi_asid_q,
        lo1_q[0] & lo0_q[0],  // Global
        hi_vpn2_q,
        lo1_q[29:6],
        lo1_q[2:1],
        lo0_q[29:6],
        lo0_q[2:1],
        index_q
    };

endmodule

`default_nettype wire

/* logic/exc_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exc_ctrl
    import cp0_pkg::*;
    import exc_pkg::*;
#(
    parameter logic [31:0] RESET_VECTOR_BASE = BEV_BASE
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [EXC_REQ_W-1:0]  exc_req_i,
    input  wire [31:0]           exc_pc_i,
    input  wire                  exc_bd_i,
    input  wire                  eret_i,
    input  wire cp0_wdata_u      status_i,
    input  wire cp0_wdata_u      cause_i,
    input  wire [19:0]           ebase_i,
    input  wire [31:0]           epc_i,
    output logic                 en_exp_o,
    output logic [4:0]           exp_code_o,
    output logic [31:0]          exp_epc_o,
    output logic                 exp_bd_o,
    output logic                 exp_badv_we_o,
    output logic                 clean_exl_o,
    output logic                 exc_taken_o,
    output logic [31:0]          exc_vector_o,
    output logic [31:0]          eret_target_o
);

    logic [7:0]  int_pending;
    logic        int_req;
    logic        pipe_req;
    logic [4:0]  req_code;
    logic [31:0] vec_offset;
    logic        eret_pending;

    assign int_pending = {cause_i.cause.ip_hw, cause_i.cause.ip_sw} & status_i.status.im;
    assign int_req = (|int_pending) & status_i.status.ie
                   & ~status_i.status.exl & ~status_i.status.erl;
    assign pipe_req = |exc_req_i;

    // Lowest set request bit wins
    always_comb begin
        req_code = EXC_INT;
        for (int i = EXC_REQ_W - 1; i >= 0; i--) begin
            if (exc_req_i[i])
                req_code = EXC_REQ_CODE[i];
        end
    end

    assign en_exp_o = pipe_req | int_req;
    assign exc_taken_o = en_exp_o;
    assign exp_code_o = req_code;
    assign exp_epc_o = exc_pc_i;
    assign exp_bd_o = exc_bd_i;
    assign exp_badv_we_o = pipe_req &
        (req_code inside {EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL, EXC_ADES});

    // Special interrupt vector only for a plain interrupt entry
    assign vec_offset = (!pipe_req && cause_i.cause.iv) ? VEC_INTERRUPT : VEC_GENERAL;
    assign exc_vector_o = status_i.status.bev ? RESET_VECTOR_BASE + VEC_GENERAL
                                              : {ebase_i, 12'b0} + vec_offset;

    // Exception entry beats a same-cycle ERET
    assign clean_exl_o = eret_i & ~en_exp_o & ~eret_pending;
    assign eret_target_o = epc_i;

    always_ff @(posedge clk) begin
        if (!rst_n)
            eret_pending <= 1'b0;
        else
            eret_pending <= clean_exl_o; // Blocks back-to-back ERET
    end

endmodule

`default_nettype wire

/* logic/cp0_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_top
    import cp0_pkg::*;
    import exc_pkg::*;
#(
    parameter logic [31:0] RESET_VECTOR_BASE = BEV_BASE
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire [4:0]            rd_addr_i,
    input  wire [2:0]            rd_sel_i,
    input  wire                  we_i,
    input  wire [4:0]            wr_addr_i,
    input  wire [2:0]            wr_sel_i,
    input  wire [31:0]           wdata_i,
    input  wire [5:0]            hw_int_i,
    input  wire [EXC_REQ_W-1:0]  exc_req_i,
    input  wire [31:0]           exc_pc_i,
    input  wire                  exc_bd_i,
    input  wire [31:0]           exc_badvaddr_i,
    input  wire                  eret_i,
    input  wire                  probe_we_i,
    input  wire [31:0]           probe_result_i,
    input  wire [4:0]            dbg_rd_addr_i,
    input  wire [2:0]            dbg_rd_sel_i,
    output logic [31:0]          cp0_data_o,
    output logic [31:0]          dbg_data_o,
    output logic                 exc_taken_o,
    output logic [31:0]          exc_vector_o,
    output logic [31:0]          eret_target_o,
    output logic                 user_mode_o,
    output logic [7:0]           asid_o,
    output logic [89:0]          tlb_config_o,
    output logic                 kseg0_uncached_o
);

    cp0_wdata_u  status;
    cp0_wdata_u  cause;
    logic [19:0] ebase;
    logic [31:0] epc;
    logic        en_exp;
    logic [4:0]  exp_code;
    logic [31:0] exp_epc;
    logic        exp_bd;
    logic        exp_badv_we;
    logic        clean_exl;

    cp0_regs u_regs (
        .clk              (clk),
        .rst_n            (rst_n),
        .rd_addr_i        (rd_addr_i),
        .rd_sel_i         (rd_sel_i),
        .we_i             (we_i),
        .wr_addr_i        (wr_addr_i),
        .wr_sel_i         (wr_sel_i),
        .wdata_i          (wdata_i),
        .hw_int_i         (hw_int_i),
        .en_exp_i         (en_exp),
        .exp_epc_i        (exp_epc),
        .exp_bd_i         (exp_bd),
        .exp_code_i       (exp_code),
        .exp_badvaddr_i   (exc_badvaddr_i),
        .exp_badv_we_i    (exp_badv_we),
        .clean_exl_i      (clean_exl),
        .probe_we_i       (probe_we_i),
        .probe_result_i   (probe_result_i),
        .dbg_rd_addr_i    (dbg_rd_addr_i),
        .dbg_rd_sel_i     (dbg_rd_sel_i),
        .data_o           (cp0_data_o),
        .dbg_data_o       (dbg_data_o),
        .status_o         (status),
        .cause_o          (cause),
        .ebase_o          (ebase),
        .epc_o            (epc),
        .timer_int_o      (),           // Already folded into Cause IP7
        .user_mode_o      (user_mode_o),
        .asid_o           (asid_o),
        .tlb_config_o     (tlb_config_o),
        .kseg0_uncached_o (kseg0_uncached_o)
    );

    exc_ctrl #(
        .RESET_VECTOR_BASE (RESET_VECTOR_BASE)
    ) u_exc (
        .clk           (clk),
        .rst_n         (rst_n),
        .exc_req_i     (exc_req_i),
        .exc_pc_i      (exc_pc_i),
        .exc_bd_i      (exc_bd_i),
        .eret_i        (eret_i),
        .status_i      (status),
        .cause_i       (cause),
        .ebase_i       (ebase),
        .epc_i         (epc),
        .en_exp_o      (en_exp),
        .exp_code_o    (exp_code),
        .exp_epc_o     (exp_epc),
        .exp_bd_o      (exp_bd),
        .exp_badv_we_o (exp_badv_we),
        .clean_exl_o   (clean_exl),
        .exc_taken_o   (exc_taken_o),
        .exc_vector_o  (exc_vector_o),
        .eret_target_o (eret_target_o)
    );

endmodule

`default_nettype wire

/* verification/cp0_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_sva
    import cp0_pkg::*;
    import exc_pkg::*;
(
    input wire                 clk,
    input wire                 rst_n,
    input wire [EXC_REQ_W-1:0] exc_req_i,
    input wire cp0_wdata_u     status_i,
    input wire                 en_exp_o,
    input wire                 clean_exl_o,
    input wire                 exc_taken_o
);

    entry_sets_exl: assert property (@(posedge clk) disable iff (!rst_n)
        en_exp_o |=> status_i.status.exl)
        else $error("EXL did not set after an exception entry");

    eret_clears_exl: assert property (@(posedge clk) disable iff (!rst_n)
        clean_exl_o |=> !status_i.status.exl)
        else $error("EXL still set after an ERET");

    // Only pipeline requests may nest
    no_int_in_exl: assert property (@(posedge clk) disable iff (!rst_n)
        (status_i.status.exl && !(|exc_req_i)) |-> !exc_taken_o)
        else $error("Interrupt taken while EXL is set");

endmodule

bind exc_ctrl cp0_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .exc_req_i   (exc_req_i),
    .status_i    (status_i),
    .en_exp_o    (en_exp_o),
    .clean_exl_o (clean_exl_o),
    .exc_taken_o (exc_taken_o)
);

`default_nettype wire

/* verification/cp0_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cp0_tb
    import cp0_pkg::*;
    import exc_pkg::*;
();

    localparam int MAX_OPS = 96;
    localparam logic [31:0] OP_WRITE = 32'h0;
    localparam logic [31:0] OP_READ  = 32'h1;
    localparam logic [31:0] OP_DBG   = 32'h2;
    localparam logic [31:0] OP_EXC   = 32'h3;
    localparam logic [31:0] OP_ERET  = 32'h4;
    localparam logic [31:0] OP_WAIT  = 32'h5;
    localparam logic [31:0] OP_RAND  = 32'h6;
    localparam logic [31:0] OP_QUIET = 32'h7;
    localparam logic [31:0] OP_END   = 32'hF;

    logic                 clk;
    logic                 rst_n;
    logic [4:0]           rd_addr;
    logic [2:0]           rd_sel;
    logic                 we;
    logic [4:0]           wr_addr;
    logic [2:0]           wr_sel;
    logic [31:0]          wdata;
    logic [5:0]           hw_int;
    logic [EXC_REQ_W-1:0] exc_req;
    logic [31:0]          exc_pc;
    logic                 exc_bd;
    logic [31:0]          exc_badvaddr;
    logic                 eret;
    logic                 probe_we;
    logic [31:0]          probe_result;
    logic [4:0]           dbg_rd_addr;
    logic [2:0]           dbg_rd_sel;
    logic [31:0]          cp0_data;
    logic [31:0]          dbg_data;
    logic                 exc_taken;
    logic [31:0]          exc_vector;
    logic [31:0]          eret_target;
    logic                 user_mode;
    logic [7:0]           asid;
    logic [89:0]          tlb_config;
    logic                 kseg0_uncached;

    logic [31:0] vec_mem [MAX_OPS*6]; // Six words per operation
    integer      seed;
    int          cur_test;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          base;
    logic        stop;

    cp0_top #(
        .RESET_VECTOR_BASE (BEV_BASE)
    ) DUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .rd_addr_i        (rd_addr),
        .rd_sel_i         (rd_sel),
        .we_i             (we),
        .wr_addr_i        (wr_addr),
        .wr_sel_i         (wr_sel),
        .wdata_i          (wdata),
        .hw_int_i         (hw_int),
        .exc_req_i        (exc_req),
        .exc_pc_i         (exc_pc),
        .exc_bd_i         (exc_bd),
        .exc_badvaddr_i   (exc_badvaddr),
        .eret_i           (eret),
        .probe_we_i       (probe_we),
        .probe_result_i   (probe_result),
        .dbg_rd_addr_i    (dbg_rd_addr),
        .dbg_rd_sel_i     (dbg_rd_sel),
        .cp0_data_o       (cp0_data),
        .dbg_data_o       (dbg_data),
        .exc_taken_o      (exc_taken),
        .exc_vector_o     (exc_vector),
        .eret_target_o    (eret_target),
        .user_mode_o      (user_mode),
        .asid_o           (asid),
        .tlb_config_o     (tlb_config),
        .kseg0_uncached_o (kseg0_uncached)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic drive_idle();
        we = 1'b0;
        exc_req = '0;
        exc_pc = 32'b0;
        exc_bd = 1'b0;
        exc_badvaddr = 32'b0;
        eret = 1'b0;
        probe_we = 1'b0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
        drive_idle();
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
        test_checks++;
        assert (got === exp_val) else begin
            $display("[ERROR] %s = %h, expected %h (test %0d)", name, got, exp_val, cur_test);
            test_errors++;
        end
    endtask

    // Level outputs that follow the register just read
    task automatic check_side_outputs(input logic [7:0] key, input logic [31:0] word);
        case (key)
            CP0_CONFIG:
                check_word("kseg0_uncached_o", {31'b0, kseg0_uncached},
                           {31'b0, word[2:0] == 3'd2});
            CP0_STATUS:
                check_word("user_mode_o", {31'b0, user_mode},
                           {31'b0, word[4] & ~word[2] & ~word[1]});
            CP0_ENTRYHI: begin
                check_word("asid_o", {24'b0, asid}, {24'b0, word[7:0]});
                check_word("tlb_config_o", {13'b0, tlb_config[74:56]},
                           {13'b0, word[31:13]});
            end
            CP0_ENTRYLO0:
                check_word("tlb_config_o", {8'b0, tlb_config[29:6]}, {8'b0, word[29:6]});
            default: ;
        endcase
    endtask

    task automatic finish_test();
        $display("Test %0d finished: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    // Returns at the negedge where exc_taken_o is seen high
    task automatic wait_for_taken(input int limit, output logic seen);
        int n;
        seen = 1'b0;
        n = 0;
        while (!seen && n < limit) begin
            @(negedge clk);
            if (exc_taken)
                seen = 1'b1;
            else
                next_cycle();
            n++;
        end
    endtask

    task automatic apply_op(input int idx, input logic [31:0] op, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] req,
                            input logic [31:0] exp_val, output logic halt);
        logic [31:0] rnd;
        logic        seen;
        int          n;
        halt = 1'b0;
        next_cycle();
        case (op)
            OP_WRITE: begin
                we = 1'b1;
                {wr_addr, wr_sel} = addr[7:0];
                wdata = data;
            end
            OP_READ: begin
                {rd_addr, rd_sel} = addr[7:0];
                @(negedge clk);
                check_word("cp0_data_o", cp0_data, exp_val);
                check_side_outputs(addr[7:0], exp_val);
            end
            OP_DBG: begin
                {dbg_rd_addr, dbg_rd_sel} = addr[7:0];
                {rd_addr, rd_sel} = data[7:0];
                @(negedge clk);
                check_word("dbg_data_o", dbg_data, exp_val);
            end
            OP_EXC: begin
                exc_req = req[EXC_REQ_W-1:0];
                exc_bd = req[8];
                exc_pc = data;
                exc_badvaddr = addr;
                @(negedge clk);
                check_word("exc_taken_o", {31'b0, exc_taken}, 32'h1);
                check_word("exc_vector_o", exc_vector, exp_val);
            end
            OP_ERET: begin
                eret = 1'b1;
                @(negedge clk);
                check_word("eret_target_o", eret_target, exp_val);
            end
            OP_WAIT: begin
                wait_for_taken(data, seen);
                if (seen) begin
                    check_word("exc_vector_o", exc_vector, exp_val);
                end else begin
                    $display("Timeout in test %0d: no exception taken within %0d cycles",
                             cur_test, data);
                    test_errors++;
                    halt = 1'b1;
                end
            end
            OP_RAND: begin
                rnd = $random(seed);
                we = 1'b1;
                {wr_addr, wr_sel} = addr[7:0];
                wdata = rnd;
                next_cycle();
                {rd_addr, rd_sel} = addr[7:0];
                @(negedge clk);
                check_word("cp0_data_o", cp0_data, (rnd & data) | exp_val);
                check_side_outputs(addr[7:0], (rnd & data) | exp_val);
            end
            OP_QUIET: begin
                for (n = 0; n < data; n++) begin
                    if (n > 0)
                        next_cycle();
                    @(negedge clk);
                    check_word("exc_taken_o", {31'b0, exc_taken}, 32'h0);
                end
            end
            default: begin
                $display("Vector %0d has an unknown operation code %h", idx, op);
                test_errors++;
                halt = 1'b1;
            end
        endcase
    endtask

    initial begin
        seed = 53600;
        rst_n = 1'b0;
        rd_addr = 5'b0;
        rd_sel = 3'b0;
        wr_addr = 5'b0;
        wr_sel = 3'b0;
        wdata = 32'b0;
        hw_int = 6'b0;
        probe_result = 32'b0;
        dbg_rd_addr = 5'b0;
        dbg_rd_sel = 3'b0;
        drive_idle();
        cur_test = 0;
        test_checks = 0;
        test_errors = 0;
        total_checks = 0;
        total_errors = 0;
        stop = 1'b0;
        $readmemh("verification/cp0_vectors.txt", vec_mem);

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int idx = 0; idx < MAX_OPS && !stop; idx++) begin
            base = idx * 6;
            if (vec_mem[base + 1] === OP_END) begin
                stop = 1'b1;
            end else begin
                if (vec_mem[base] != cur_test) begin
                    if (cur_test != 0)
                        finish_test();
                    cur_test = vec_mem[base];
                end
                apply_op(idx, vec_mem[base + 1], vec_mem[base + 2], vec_mem[base + 3],
                         vec_mem[base + 4], vec_mem[base + 5], stop);
            end
        end
        if (cur_test != 0 || test_errors != 0)
            finish_test();

        $display("Summary: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0 && total_checks > 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/cp0_pkg.sv
logic/exc_pkg.sv
logic/cp0_regs.sv
logic/exc_ctrl.sv
logic/cp0_top.sv
verification/cp0_sva.sv
verification/cp0_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CP0 testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cp0_tb -f all.f -o cp0_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/cp0_sim)" || echo "Simulator returned a failing status"
echo "$sim_out"

echo "$sim_out" | grep -qx "NO ERRORS" && exit 0 || exit 1

/* verification/cp0_vectors.txt */
// test op addr data req expect, all hex
// op 0 write, 1 read, 2 dbg read (data = main port addr), 3 exception (addr = badvaddr,
// data = pc, req[8] = bd), 4 eret, 5 wait for taken (data = limit), 6 random write and
// readback (data = mask, expect = fixed bits), 7 no exception (data = cycles), F end
1 1 60 00000000 0 10400004 // Status after reset
1 1 78 00000000 0 00018000 // PRId
1 1 81 00000000 0 1E281400 // Config1
1 1 80 00000000 0 80000083 // Config, K0 = 3
1 6 10 3FFFFFFF 0 00000000 // EntryLo0
1 6 18 3FFFFFFF 0 00000000 // EntryLo1
1 6 50 FFFFE0FF 0 00000000 // EntryHi
1 6 70 FFFFFFFF 0 00000000 // EPC
1 6 79 3FFFF000 0 80000000 // EBase
1 6 80 00000007 0 80000080 // Config K0
1 0 10 FFFFFFFF 0 00000000
1 1 10 00000000 0 3FFFFFFF // EntryLo0 upper bits zero
1 0 79 FFFFFFFF 0 00000000
1 1 79 00000000 0 BFFFF000
1 0 48 00000100 0 00000000 // Count
1 1 48 00000000 0 00000100
2 0 18 FFFFFFFF 0 00000000
2 2 18 00000060 0 3FFFFFFF // main port on Status
2 2 78 00000018 0 00018000 // main port on EntryLo1
2 2 60 00000078 0 10400004 // main port on PRId
3 3 12345678 BFC00100 00000102 BFC00380 // TLBL in delay slot
3 1 70 00000000 0 BFC00100
3 1 68 00000000 0 80000008
3 1 60 00000000 0 10400006
3 1 40 00000000 0 12345678
3 3 87654320 BFC00200 00000081 BFC00380 // bit 0 beats bit 7
3 1 68 00000000 0 00000010
3 1 70 00000000 0 BFC00200
3 1 40 00000000 0 87654320
3 3 DEADBEEF BFC00300 00000008 BFC00380 // syscall keeps BadVAddr
3 1 68 00000000 0 00000020
3 1 40 00000000 0 87654320
4 4 00 00000000 0 BFC00300
4 1 60 00000000 0 10400004
5 0 79 00345000 0 00000000
5 1 79 00000000 0 80345000
5 0 68 00000000 0 00000000
5 0 48 00000000 0 00000000
5 0 58 00000040 0 00000000
5 0 60 10008001 0 00000000 // IE, IM7, ERL and BEV clear
5 5 00 0000012C 0 80345180
5 1 68 00000000 0 00008000 // IP7 from timer
5 0 58 00000000 0 00000000
5 1 68 00000000 0 00000000
5 4 00 00000000 0 00000000
5 0 68 00800000 0 00000000 // IV set
5 0 48 00000000 0 00000000
5 0 58 00000040 0 00000000
5 5 00 0000012C 0 80345200
5 1 68 00000000 0 00808000
5 0 58 00000000 0 00000000
5 4 00 00000000 0 00000000
6 0 68 00000100 0 00000000 // software IP0, IV clear
6 7 00 00000008 0 00000000
6 0 60 10008101 0 00000000 // unmask IM0
6 5 00 00000014 0 80345180
6 1 68 00000000 0 00000100
6 0 68 00000000 0 00000000
6 4 00 00000000 0 00000000
F F 00 00000000 0 00000000
